/* dv/lsu_chk.sv */
`default_nettype none

module lsu_chk (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            issue_ready_i,
    input logic            result_valid_i,
    input logic            result_ready_i,
    input lsu_pkg::id_t    result_id_i,
    input lsu_pkg::data_t  result_data_i,
    input lsu_pkg::cause_e result_cause_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int unsigned fail_count = 0;

    // ------------------------------------------------------------------------
    // result port handshake
    // ------------------------------------------------------------------------
    // a stalled result keeps its valid and its payload
    property result_held_p;
        @(posedge clk_i) disable iff (!rst_ni)
        result_valid_i && !result_ready_i |=>
            result_valid_i && $stable(result_id_i) && $stable(result_data_i) &&
            $stable(result_cause_i);
    endproperty

    result_held_a: assert property (result_held_p)
        else begin
            fail_count++;
            $error("result changed while result_ready_i was held low");
        end

    // both handshake outputs defined once out of reset
    handshake_known_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !$isunknown({issue_ready_i, result_valid_i}))
        else begin
            fail_count++;
            $error("issue_ready_o or result_valid_o is unknown after reset");
        end

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
`default_nettype none

module lsu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned CLK_PERIOD   = 40;
    localparam int unsigned RESET_CYCLES = 5;
    localparam logic [31:0] SEED         = 32'hbfa5;
    localparam int unsigned MEM_BYTES    = 4 * lsu_pkg::MEM_WORDS;
    localparam int unsigned N_SUB        = 400;
    localparam int unsigned N_EXC        = 16;
    localparam int unsigned N_MIX        = 600;
    // eight operations per exception round
    localparam int unsigned TOTAL_OPS    = 2 * lsu_pkg::MEM_WORDS + N_SUB + 8 * N_EXC + N_MIX;
    localparam int unsigned TIMEOUT_NS   = (TOTAL_OPS * 20 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        lsu_pkg::id_t    id;
        lsu_pkg::data_t  data;
        lsu_pkg::cause_e cause;
    } expect_t;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      issue_valid_i;
    logic                      issue_ready_o;
    lsu_pkg::lsu_op_e          issue_op_i;
    lsu_pkg::data_t            issue_base_i;
    logic [lsu_pkg::IMM_W-1:0] issue_imm_i;
    lsu_pkg::data_t            issue_wdata_i;
    lsu_pkg::id_t              issue_id_i;
    logic                      result_valid_o;
    logic                      result_ready_i;
    lsu_pkg::id_t              result_id_o;
    lsu_pkg::data_t            result_data_o;
    lsu_pkg::cause_e           result_cause_o;

    // reference model state
    logic [7:0]     mem_model [MEM_BYTES];
    expect_t        exp_q [$];
    lsu_pkg::id_t   next_id;
    logic [31:0]    stim_state;
    logic [31:0]    bp_state;
    logic           ready_random;
    string          test_name;

    lsu_top i_lsu_top (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .issue_valid_i  ( issue_valid_i  ),
        .issue_ready_o  ( issue_ready_o  ),
        .issue_op_i     ( issue_op_i     ),
        .issue_base_i   ( issue_base_i   ),
        .issue_imm_i    ( issue_imm_i    ),
        .issue_wdata_i  ( issue_wdata_i  ),
        .issue_id_i     ( issue_id_i     ),
        .result_valid_o ( result_valid_o ),
        .result_ready_i ( result_ready_i ),
        .result_id_o    ( result_id_o    ),
        .result_data_o  ( result_data_o  ),
        .result_cause_o ( result_cause_o )
    );

    bind lsu_top lsu_chk i_lsu_chk (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .issue_ready_i  ( issue_ready_o  ),
        .result_valid_i ( result_valid_o ),
        .result_ready_i ( result_ready_i ),
        .result_id_i    ( result_id_o    ),
        .result_data_i  ( result_data_o  ),
        .result_cause_i ( result_cause_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // random numbers and compare tasks
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic lsu_pkg::data_t rand_stim();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    task automatic check_data(input string name, input lsu_pkg::data_t exp,
                              input lsu_pkg::data_t act);
        if (act !== exp) begin
            $display("error: %s data expected %h actual %h", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "result data mismatch");
        end
    endtask

    task automatic check_id(input string name, input lsu_pkg::id_t exp, input lsu_pkg::id_t act);
        if (act !== exp) begin
            $display("error: %s id expected %0d actual %0d", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "result id mismatch");
        end
    endtask

    task automatic check_cause(input string name, input lsu_pkg::cause_e exp,
                               input lsu_pkg::cause_e act);
        if (act !== exp) begin
            $display("error: %s cause expected %0d actual %0d", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "result cause mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "handshake flag mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    task automatic predict(input lsu_pkg::lsu_op_e op, input lsu_pkg::data_t base,
                           input logic [lsu_pkg::IMM_W-1:0] imm, input lsu_pkg::data_t wdata,
                           input lsu_pkg::id_t id);
        lsu_pkg::data_t  addr;
        lsu_pkg::data_t  data;
        lsu_pkg::cause_e cause;
        logic            store;
        int unsigned     nbytes;
        int unsigned     i;
        addr   = base + {{(lsu_pkg::DATA_W - lsu_pkg::IMM_W){imm[lsu_pkg::IMM_W-1]}}, imm};
        store  = (op == lsu_pkg::SB) || (op == lsu_pkg::SH) || (op == lsu_pkg::SW);
        nbytes = 1;
        if (op == lsu_pkg::LW || op == lsu_pkg::SW) begin
            nbytes = 4;
        end else if (op == lsu_pkg::LH || op == lsu_pkg::LHU || op == lsu_pkg::SH) begin
            nbytes = 2;
        end
        // fault beats misalignment
        if (addr >= MEM_BYTES) begin
            cause = store ? lsu_pkg::ST_ACCESS_FAULT : lsu_pkg::LD_ACCESS_FAULT;
        end else if (addr % nbytes != 0) begin
            cause = store ? lsu_pkg::ST_MISALIGNED : lsu_pkg::LD_MISALIGNED;
        end else begin
            cause = lsu_pkg::NONE;
        end
        data = '0;
        if (cause != lsu_pkg::NONE) begin
            data = addr;
        end else if (store) begin
            for (i = 0; i < nbytes; i++) begin
                mem_model[addr + i] = wdata[8*i +: 8];
            end
        end else begin
            for (i = 0; i < nbytes; i++) begin
                data[8*i +: 8] = mem_model[addr + i];
            end
            if (op == lsu_pkg::LB) begin
                data = {{24{data[7]}}, data[7:0]};
            end else if (op == lsu_pkg::LH) begin
                data = {{16{data[15]}}, data[15:0]};
            end
        end
        exp_q.push_back(expect_t'{id: id, data: data, cause: cause});
    endtask

    // issue one operation at a byte address, with a random immediate split
    task automatic issue_at(input lsu_pkg::lsu_op_e op, input lsu_pkg::data_t addr,
                            input lsu_pkg::data_t wdata);
        lsu_pkg::data_t            r;
        logic [lsu_pkg::IMM_W-1:0] imm;
        r             = rand_stim();
        imm           = r[lsu_pkg::IMM_W-1:0];
        issue_valid_i = 1'b1;
        issue_op_i    = op;
        issue_imm_i   = imm;
        issue_base_i  = addr - {{(lsu_pkg::DATA_W - lsu_pkg::IMM_W){imm[lsu_pkg::IMM_W-1]}}, imm};
        issue_wdata_i = wdata;
        issue_id_i    = next_id;
        @(posedge clk_i);
        while (!issue_ready_o) begin
            @(posedge clk_i);
        end
        predict(op, issue_base_i, imm, wdata, next_id);
        next_id = next_id + 1'b1;
        #2;
    endtask

    task automatic drain();
        issue_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    // ------------------------------------------------------------------------
    // result monitor, back-pressure and watchdog
    // ------------------------------------------------------------------------
    initial begin : monitor
        expect_t exp;
        forever begin
            @(posedge clk_i);
            if (rst_ni && result_valid_o && result_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("error: result with id %0d arrived with nothing outstanding",
                             result_id_o);
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected result");
                end
                exp = exp_q.pop_front();
                check_id(test_name, exp.id, result_id_o);
                check_data(test_name, exp.data, result_data_o);
                check_cause(test_name, exp.cause, result_cause_o);
            end
        end
    end

    initial begin
        wait (i_lsu_top.i_lsu_chk.fail_count != 0);
        $display("error: an assertion of the bound checker failed");
        $display("=== FAIL ===");
        $fatal(1, "assertion failure");
    end

    initial begin
        forever begin
            @(posedge clk_i);
            #2;
            bp_state       = xorshift(bp_state);
            result_ready_i = ready_random ? bp_state[7] : 1'b1;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("error: no progress after %0d ns, results stopped arriving", TIMEOUT_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin : main
        lsu_pkg::data_t r;
        lsu_pkg::data_t a;
        int unsigned    n;
        stim_state     = SEED;
        bp_state       = ~SEED;
        ready_random   = 1'b0;
        next_id        = '0;
        rst_ni         = 1'b0;
        issue_valid_i  = 1'b0;
        issue_op_i     = lsu_pkg::LB;
        issue_base_i   = '0;
        issue_imm_i    = '0;
        issue_wdata_i  = '0;
        issue_id_i     = '0;
        result_ready_i = 1'b1;

        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(posedge clk_i);
        check_flag("reset result_valid_o", 1'b0, result_valid_o);
        check_flag("reset issue_ready_o", 1'b1, issue_ready_o);
        #2;

        test_name = "fill_read";
        for (n = 0; n < lsu_pkg::MEM_WORDS; n++) begin
            issue_at(lsu_pkg::SW, 4 * n, rand_stim());
        end
        for (n = 0; n < lsu_pkg::MEM_WORDS; n++) begin
            issue_at(lsu_pkg::LW, 4 * n, '0);
        end
        drain();

        test_name = "sub_word";
        for (n = 0; n < N_SUB; n++) begin
            r = rand_stim();
            a = r % MEM_BYTES;
            case (r[15:13] % 6)
                0:       issue_at(lsu_pkg::SB, a, rand_stim());
                1:       issue_at(lsu_pkg::SH, a & ~32'd1, rand_stim());
                2:       issue_at(lsu_pkg::LB, a, '0);
                3:       issue_at(lsu_pkg::LBU, a, '0);
                4:       issue_at(lsu_pkg::LH, a & ~32'd1, '0);
                default: issue_at(lsu_pkg::LHU, a & ~32'd1, '0);
            endcase
        end
        drain();

        // faulting accesses, then a load of the word that was targeted
        test_name = "exceptions";
        for (n = 0; n < N_EXC; n++) begin
            r = rand_stim();
            a = 4 * (r % lsu_pkg::MEM_WORDS);
            issue_at(lsu_pkg::LH, a + 1, rand_stim());
            issue_at(lsu_pkg::SH, a + 1, rand_stim());
            issue_at(lsu_pkg::LW, a + 2, rand_stim());
            issue_at(lsu_pkg::SW, a + 3, rand_stim());
            issue_at(lsu_pkg::SB, rand_stim() | 32'h400, rand_stim());
            issue_at(lsu_pkg::LBU, rand_stim() | 32'h400, '0);
            issue_at(lsu_pkg::SW, rand_stim() | 32'h401, rand_stim());
            issue_at(lsu_pkg::LW, a, '0);
        end
        drain();

        test_name    = "backpressure";
        ready_random = 1'b1;
        for (n = 0; n < N_MIX; n++) begin
            r = rand_stim();
            if (r[1:0] == 2'd0) begin
                issue_valid_i = 1'b0;
                repeat (r[3:2] + 1) begin
                    @(posedge clk_i);
                end
                #2;
            end
            a = (r[11:8] == 4'd0) ? rand_stim() : rand_stim() % 1100;
            issue_at(lsu_pkg::lsu_op_e'(r[6:4]), a, rand_stim());
        end
        drain();
        ready_random = 1'b0;

        // a few idle cycles so that a duplicate result would show up
        repeat (4) @(posedge clk_i);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/lsu_agu.sv */
`default_nettype none

module lsu_agu (
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  lsu_pkg::lsu_op_e          issue_op_i,
    input  lsu_pkg::data_t            issue_base_i,
    input  logic [lsu_pkg::IMM_W-1:0] issue_imm_i,
    input  lsu_pkg::data_t            issue_wdata_i,
    input  lsu_pkg::id_t              issue_id_i,
    lsu_req_if.src                    req
);

    lsu_pkg::data_t     imm_ext;
    lsu_pkg::lsu_addr_u addr;
    logic               is_store;
    logic               is_half;
    logic               is_word;
    logic               misaligned;

    // ------------------------------------------------------------------------
    // address generation
    // ------------------------------------------------------------------------
    assign imm_ext  = {{(lsu_pkg::DATA_W - lsu_pkg::IMM_W){issue_imm_i[lsu_pkg::IMM_W-1]}},
                       issue_imm_i};
    assign addr.raw = issue_base_i + imm_ext;

    // access size and direction
    always_comb begin
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (issue_op_i)
            lsu_pkg::LH, lsu_pkg::LHU: is_half = 1'b1;
            lsu_pkg::LW:               is_word = 1'b1;
            lsu_pkg::SB:               is_store = 1'b1;
            lsu_pkg::SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            lsu_pkg::SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;
        endcase
    end

    // byte accesses are always aligned
    assign misaligned = (is_half && addr.f.offset[0]) || (is_word && (addr.f.offset != '0));

    // byte lanes and store data replication
    always_comb begin
        if (is_word) begin
            req.be    = '1;
            req.wdata = issue_wdata_i;
        end else if (is_half) begin
            req.be    = lsu_pkg::be_t'(4'b0011) << addr.f.offset;
            req.wdata = {2{issue_wdata_i[15:0]}};
        end else begin
            req.be    = lsu_pkg::be_t'(4'b0001) << addr.f.offset;
            req.wdata = {4{issue_wdata_i[7:0]}};
        end
    end

    // access fault wins over misalignment
    always_comb begin
        if (addr.f.upper != '0) begin
            req.cause = is_store ? lsu_pkg::ST_ACCESS_FAULT : lsu_pkg::LD_ACCESS_FAULT;
        end else if (misaligned) begin
            req.cause = is_store ? lsu_pkg::ST_MISALIGNED : lsu_pkg::LD_MISALIGNED;
        end else begin
            req.cause = lsu_pkg::NONE;
        end
    end

    assign req.valid     = issue_valid_i;
    assign req.op        = issue_op_i;
    assign req.addr      = addr;
    assign req.id        = issue_id_i;
    assign issue_ready_o = req.ready;

endmodule

`default_nettype wire

/* hdl/lsu_mem_access.sv */
`default_nettype none

module lsu_mem_access (
    input  logic            clk_i,
    input  logic            rst_ni,
    lsu_req_if.dst          req,
    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output lsu_pkg::id_t    rsp_id_o,
    output lsu_pkg::data_t  rsp_data_o,
    output lsu_pkg::cause_e rsp_cause_o
);

    lsu_pkg::data_t mem_q [lsu_pkg::MEM_WORDS];

    logic                      accept;
    logic                      is_store;
    logic                      do_write;
    logic                      rsp_valid_q;
    lsu_pkg::id_t              id_q;
    lsu_pkg::lsu_op_e          op_q;
    lsu_pkg::cause_e           cause_q;
    logic [lsu_pkg::OFF_W-1:0] offset_q;
    lsu_pkg::data_t            word_q;
    lsu_pkg::data_t            shifted;

    // output slot is free or drains this cycle
    assign req.ready = !rsp_valid_q || rsp_ready_i;
    assign accept    = req.valid && req.ready;
    assign is_store  = (req.op == lsu_pkg::SB) || (req.op == lsu_pkg::SH) ||
                       (req.op == lsu_pkg::SW);
    assign do_write  = accept && is_store && (req.cause == lsu_pkg::NONE);

    // ------------------------------------------------------------------------
    // scratchpad
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            for (int i = 0; i < lsu_pkg::BE_W; i++) begin
                if (req.be[i]) begin
                    mem_q[req.addr.f.index][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, fault address or zero for stores
    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_q     <= req.id;
            op_q     <= req.op;
            cause_q  <= req.cause;
            offset_q <= req.addr.f.offset;
            if (req.cause != lsu_pkg::NONE) begin
                word_q <= req.addr.raw;
            end else if (is_store) begin
                word_q <= '0;
            end else begin
                word_q <= mem_q[req.addr.f.index];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else if (req.ready) begin
            rsp_valid_q <= req.valid;
        end
    end

    // ------------------------------------------------------------------------
    // load extraction
    // ------------------------------------------------------------------------
    assign shifted = word_q >> {offset_q, 3'b000};

    always_comb begin
        rsp_data_o = word_q;
        if (cause_q == lsu_pkg::NONE) begin
            case (op_q)
                lsu_pkg::LB:  rsp_data_o = {{(lsu_pkg::DATA_W-8){shifted[7]}}, shifted[7:0]};
                lsu_pkg::LBU: rsp_data_o = {{(lsu_pkg::DATA_W-8){1'b0}}, shifted[7:0]};
                lsu_pkg::LH:  rsp_data_o = {{(lsu_pkg::DATA_W-16){shifted[15]}}, shifted[15:0]};
                lsu_pkg::LHU: rsp_data_o = {{(lsu_pkg::DATA_W-16){1'b0}}, shifted[15:0]};
                // LW and the stores pass the word through
                default:      rsp_data_o = word_q;
            endcase
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_id_o    = id_q;
    assign rsp_cause_o = cause_q;

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // ------------------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------------------
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned ID_W      = 4;
    localparam int unsigned IMM_W     = 12;
    localparam int unsigned BE_W      = DATA_W / 8;
    localparam int unsigned MEM_WORDS = 256;

    // address split for the scratchpad
    localparam int unsigned OFF_W     = $clog2(BE_W);
    localparam int unsigned IDX_W     = $clog2(MEM_WORDS);
    localparam int unsigned UPPER_W   = DATA_W - IDX_W - OFF_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [BE_W-1:0]   be_t;

    // ------------------------------------------------------------------------
    // opcodes and exception causes
    // ------------------------------------------------------------------------
    // stores sit above the loads
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LBU = 3'd1,
        LH  = 3'd2,
        LHU = 3'd3,
        LW  = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } lsu_op_e;

    // risc-v mcause encoding
    typedef enum logic [3:0] {
        NONE            = 4'd0,
        LD_MISALIGNED   = 4'd4,
        LD_ACCESS_FAULT = 4'd5,
        ST_MISALIGNED   = 4'd6,
        ST_ACCESS_FAULT = 4'd7
    } cause_e;

    // ------------------------------------------------------------------------
    // byte address, raw or split into fields
    // ------------------------------------------------------------------------
    // upper field non-zero means outside the scratchpad
    typedef union packed {
        data_t raw;
        struct packed {
            logic [UPPER_W-1:0] upper;
            logic [IDX_W-1:0]   index;
            logic [OFF_W-1:0]   offset;
        } f;
    } lsu_addr_u;

endpackage

`default_nettype wire

/* hdl/lsu_req_buffer.sv */
`default_nettype none

module lsu_req_buffer (
    input  logic   clk_i,
    input  logic   rst_ni,
    lsu_req_if.dst in_req,
    lsu_req_if.src out_req
);

    // two entries, so one-bit pointers
    lsu_pkg::lsu_op_e   op_q    [2];
    lsu_pkg::lsu_addr_u addr_q  [2];
    lsu_pkg::be_t       be_q    [2];
    lsu_pkg::data_t     wdata_q [2];
    lsu_pkg::id_t       id_q    [2];
    lsu_pkg::cause_e    cause_q [2];

    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       empty;
    logic       push;
    logic       pop;

    assign empty        = (count_q == 2'd0);
    assign in_req.ready = (count_q != 2'd2);

    // store only what the memory stage did not take straight away
    assign pop  = !empty && out_req.ready;
    assign push = in_req.valid && in_req.ready && !(empty && out_req.ready);

    // bypass when empty, otherwise oldest entry
    always_comb begin
        if (empty) begin
            out_req.valid = in_req.valid;
            out_req.op    = in_req.op;
            out_req.addr  = in_req.addr;
            out_req.be    = in_req.be;
            out_req.wdata = in_req.wdata;
            out_req.id    = in_req.id;
            out_req.cause = in_req.cause;
        end else begin
            out_req.valid = 1'b1;
            out_req.op    = op_q[rd_ptr_q];
            out_req.addr  = addr_q[rd_ptr_q];
            out_req.be    = be_q[rd_ptr_q];
            out_req.wdata = wdata_q[rd_ptr_q];
            out_req.id    = id_q[rd_ptr_q];
            out_req.cause = cause_q[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            if (push && !pop) begin
                count_q <= count_q + 2'd1;
            end else if (pop && !push) begin
                count_q <= count_q - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            op_q[wr_ptr_q]    <= in_req.op;
            addr_q[wr_ptr_q]  <= in_req.addr;
            be_q[wr_ptr_q]    <= in_req.be;
            wdata_q[wr_ptr_q] <= in_req.wdata;
            id_q[wr_ptr_q]    <= in_req.id;
            cause_q[wr_ptr_q] <= in_req.cause;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_req_if.sv */
`default_nettype none

interface lsu_req_if;

    // handshake
    logic               valid;
    logic               ready;

    // decoded request
    lsu_pkg::lsu_op_e   op;
    lsu_pkg::lsu_addr_u addr;
    lsu_pkg::be_t       be;
    lsu_pkg::data_t     wdata;
    lsu_pkg::id_t       id;
    lsu_pkg::cause_e    cause;

    modport src (
        output valid,
        output op,
        output addr,
        output be,
        output wdata,
        output id,
        output cause,
        input  ready
    );

    modport dst (
        input  valid,
        input  op,
        input  addr,
        input  be,
        input  wdata,
        input  id,
        input  cause,
        output ready
    );

endinterface

`default_nettype wire

/* hdl/lsu_result_reg.sv */
`default_nettype none

module lsu_result_reg (
    input  logic            clk_i,
    input  logic            rst_ni,

    // from the memory stage
    input  logic            rsp_valid_i,
    output logic            rsp_ready_o,
    input  lsu_pkg::id_t    rsp_id_i,
    input  lsu_pkg::data_t  rsp_data_i,
    input  lsu_pkg::cause_e rsp_cause_i,

    // towards the outside
    output logic            result_valid_o,
    input  logic            result_ready_i,
    output lsu_pkg::id_t    result_id_o,
    output lsu_pkg::data_t  result_data_o,
    output lsu_pkg::cause_e result_cause_o
);

    logic valid_q;

    // can take a new one while the held one leaves
    assign rsp_ready_o = !valid_q || result_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (rsp_ready_o) begin
            valid_q <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i && rsp_ready_o) begin
            result_id_o    <= rsp_id_i;
            result_data_o  <= rsp_data_i;
            result_cause_o <= rsp_cause_i;
        end
    end

    assign result_valid_o = valid_q;

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`default_nettype none

module lsu_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // issue side
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  lsu_pkg::lsu_op_e          issue_op_i,
    input  lsu_pkg::data_t            issue_base_i,
    input  logic [lsu_pkg::IMM_W-1:0] issue_imm_i,
    input  lsu_pkg::data_t            issue_wdata_i,
    input  lsu_pkg::id_t              issue_id_i,

    // in-order result side
    output logic                      result_valid_o,
    input  logic                      result_ready_i,
    output lsu_pkg::id_t              result_id_o,
    output lsu_pkg::data_t            result_data_o,
    output lsu_pkg::cause_e           result_cause_o
);

    lsu_req_if agu_req ();
    lsu_req_if mem_req ();

    logic            rsp_valid;
    logic            rsp_ready;
    lsu_pkg::id_t    rsp_id;
    lsu_pkg::data_t  rsp_data;
    lsu_pkg::cause_e rsp_cause;

    lsu_agu i_lsu_agu (
        .issue_valid_i ( issue_valid_i ),
        .issue_ready_o ( issue_ready_o ),
        .issue_op_i    ( issue_op_i    ),
        .issue_base_i  ( issue_base_i  ),
        .issue_imm_i   ( issue_imm_i   ),
        .issue_wdata_i ( issue_wdata_i ),
        .issue_id_i    ( issue_id_i    ),
        .req           ( agu_req       )
    );

    lsu_req_buffer i_lsu_req_buffer (
        .clk_i   ( clk_i   ),
        .rst_ni  ( rst_ni  ),
        .in_req  ( agu_req ),
        .out_req ( mem_req )
    );

    lsu_mem_access i_lsu_mem_access (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .req         ( mem_req   ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_ready_i ( rsp_ready ),
        .rsp_id_o    ( rsp_id    ),
        .rsp_data_o  ( rsp_data  ),
        .rsp_cause_o ( rsp_cause )
    );

    lsu_result_reg i_lsu_result_reg (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .rsp_valid_i    ( rsp_valid      ),
        .rsp_ready_o    ( rsp_ready      ),
        .rsp_id_i       ( rsp_id         ),
        .rsp_data_i     ( rsp_data       ),
        .rsp_cause_i    ( rsp_cause      ),
        .result_valid_o ( result_valid_o ),
        .result_ready_i ( result_ready_i ),
        .result_id_o    ( result_id_o    ),
        .result_data_o  ( result_data_o  ),
        .result_cause_o ( result_cause_o )
    );

endmodule

`default_nettype wire

/* verilog.f */
hdl/lsu_pkg.sv
hdl/lsu_req_if.sv
hdl/lsu_agu.sv
hdl/lsu_req_buffer.sv
hdl/lsu_mem_access.sv
hdl/lsu_result_reg.sv
hdl/lsu_top.sv
dv/lsu_chk.sv
dv/lsu_tb.sv
